// File: snakePkg.sv
// screen geometry, coordinate and colour types, direction enum, apple and start constants
`default_nettype none

package snakePkg;

    // visible area in pixels
    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // pixel column and row words
    typedef logic [7:0] xCoord;
    typedef logic [6:0] yCoord;

    // 3-bit rgb, red in the top bit
    typedef logic [2:0] colour;

    // listed in key priority order
    typedef enum logic [1:0]
    {
        dirRight,
        dirDown,
        dirUp,
        dirLeft
    } direction;

    // apple square never moves
    localparam xCoord AppleX = 8'd30;
    localparam yCoord AppleY = 7'd30;
    localparam colour AppleColour = 3'b100;

    // erased squares go back to the black background
    localparam colour EraseColour = 3'b000;

    // head origin after reset, the body hangs straight below it
    localparam xCoord StartX = 8'd80;
    localparam yCoord StartY = 7'd60;

endpackage

`default_nettype wire

// File: headSteering.sv
// key direction latch, next head cell and border detect
`timescale 1ns/10ps
`default_nettype none

module headSteering
    import snakePkg::*;
#(
    parameter int CellSize = 10
)
(
    input wire Clock,
    input wire reset,
    input wire [3:0] keys,
    input wire xCoord headX,
    input wire yCoord headY,
    output xCoord nextHeadX,
    output yCoord nextHeadY,
    output logic borderHit
);

    // one whole cell per move
    localparam xCoord StepX = xCoord'(CellSize);
    localparam yCoord StepY = yCoord'(CellSize);

    // origin of the last cell column and row on screen
    localparam xCoord LastX = xCoord'(ScreenWidth - CellSize);
    localparam yCoord LastY = yCoord'(ScreenHeight - CellSize);

    direction heading;

    // keys are active low
    // right beats down beats up beats left
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            // snake starts pointing away from its body
            heading <= dirUp;
        end
        else if (!keys[0])
        begin
            heading <= dirRight;
        end
        else if (!keys[1])
        begin
            heading <= dirDown;
        end
        else if (!keys[2])
        begin
            heading <= dirUp;
        end
        else if (!keys[3])
        begin
            heading <= dirLeft;
        end
    end

    // neighbouring cell in the latched heading
    always_comb
    begin
        nextHeadX = headX;
        nextHeadY = headY;
        case (heading)
            dirRight:
                nextHeadX = headX + StepX;
            dirLeft:
                nextHeadX = headX - StepX;
            dirDown:
                nextHeadY = headY + StepY;
            dirUp:
                nextHeadY = headY - StepY;
            default:
                nextHeadY = headY;
        endcase
    end

    // head lying on any of the four edge cells ends the game
    assign borderHit = (headX == '0) || (headX == LastX) || (headY == '0) || (headY == LastY);

endmodule

`default_nettype wire

// File: bodySegment.sv
// one snake cell position register and its overlap compare with the head
`timescale 1ns/10ps
`default_nettype none

module bodySegment
    import snakePkg::*;
#(
    parameter int CellSize = 10,
    parameter int Index = 0
)
(
    input wire Clock,
    input wire reset,
    input wire moveEnable,
    input wire xCoord inX,
    input wire yCoord inY,
    input wire xCoord headX,
    input wire yCoord headY,
    output xCoord posX,
    output yCoord posY,
    output logic hit
);

    // start row one cell lower per index
    localparam yCoord HomeY = yCoord'(StartY + CellSize * Index);

    // takes the old position of the cell ahead on each move
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            posX <= StartX;
            posY <= HomeY;
        end
        else if (moveEnable)
        begin
            posX <= inX;
            posY <= inY;
        end
    end

    // cells stay grid aligned so overlap is plain equality
    // the head never collides with itself
    if (Index == 0)
    begin : gHead
        assign hit = 1'b0;
    end
    else
    begin : gBody
        assign hit = (posX == headX) && (posY == headY);
    end

endmodule

`default_nettype wire

// File: squarePainter.sv
// square scan counters, pixel coordinate, colour and plot strobe
`timescale 1ns/10ps
`default_nettype none

module squarePainter
    import snakePkg::*;
#(
    parameter int SegmentCount = 4,
    parameter int CellSize = 10
)
(
    input wire Clock,
    input wire reset,
    input wire drawEnable,
    input wire drawApple,
    input wire erase,
    input wire [$clog2(SegmentCount)-1:0] segmentSelect,
    input wire [SegmentCount*$bits(xCoord)-1:0] segmentX,
    input wire [SegmentCount*$bits(yCoord)-1:0] segmentY,
    input wire colour playerColour,
    output xCoord pixelX,
    output yCoord pixelY,
    output colour pixelColour,
    output logic plot,
    output logic squareDone
);

    localparam int XBits = $bits(xCoord);
    localparam int YBits = $bits(yCoord);
    localparam int CountBits = $clog2(CellSize);
    localparam logic [CountBits-1:0] LastCount = CountBits'(CellSize - 1);

    // offset of the current pixel inside the square
    logic [CountBits-1:0] colCount;
    logic [CountBits-1:0] rowCount;
    // idle cycle after every row including the last
    logic rowGap;
    logic lastCol;
    xCoord originX;
    yCoord originY;

    assign lastCol = (colCount == LastCount);

    // every non-gap cycle with drawing enabled carries a pixel
    assign plot = drawEnable && !rowGap;

    // bottom right pixel
    assign squareDone = plot && lastCol && (rowCount == LastCount);

    // row by row and left to right
    always_ff @(posedge Clock)
    begin
        if (reset || !drawEnable)
        begin
            colCount <= '0;
            rowCount <= '0;
            rowGap <= 1'b0;
        end
        else if (rowGap)
        begin
            rowGap <= 1'b0;
        end
        else if (lastCol)
        begin
            colCount <= '0;
            rowGap <= 1'b1;
            // wrap lines up the next square after the gap
            rowCount <= (rowCount == LastCount) ? '0 : rowCount + 1'b1;
        end
        else
        begin
            colCount <= colCount + 1'b1;
        end
    end

    // square origin from the apple or the selected body cell
    always_comb
    begin
        if (drawApple)
        begin
            originX = AppleX;
            originY = AppleY;
        end
        else
        begin
            originX = segmentX[segmentSelect*XBits +: XBits];
            originY = segmentY[segmentSelect*YBits +: YBits];
        end
    end

    assign pixelX = originX + xCoord'(colCount);
    assign pixelY = originY + yCoord'(rowCount);

    // apple red has priority and erase paints background
    always_comb
    begin
        if (drawApple)
        begin
            pixelColour = AppleColour;
        end
        else if (erase)
        begin
            pixelColour = EraseColour;
        end
        else
        begin
            pixelColour = playerColour;
        end
    end

endmodule

`default_nettype wire

// File: gameControl.sv
// round FSM, segment index counter and frame tick divider
`timescale 1ns/10ps
`default_nettype none

module gameControl
#(
    parameter int SegmentCount = 4,
    parameter int TickBits = 20
)
(
    input wire Clock,
    input wire reset,
    input wire go,
    input wire squareDone,
    input wire borderHit,
    input wire bodyHit,
    output logic drawEnable,
    output logic drawApple,
    output logic erase,
    output logic [$clog2(SegmentCount)-1:0] segmentSelect,
    output logic moveEnable,
    output logic gameOver
);

    localparam int SelectBits = $clog2(SegmentCount);
    localparam logic [SelectBits-1:0] LastSegment = SelectBits'(SegmentCount - 1);

    typedef enum logic [2:0]
    {
        stIdle,
        stApple,
        stDrawBody,
        stWaitTick,
        stEraseBody,
        stCheck,
        stMove,
        stOver
    } roundState;

    roundState state;
    roundState nextState;

    // free running frame divider
    logic [TickBits-1:0] tickCount;
    logic tick;
    // body square being painted from the tail
    logic [SelectBits-1:0] segIndex;
    logic bodyPass;
    logic lastSquare;

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            tickCount <= '0;
        end
        else
        begin
            tickCount <= tickCount + 1'b1;
        end
    end

    // one pulse per wrap of the divider
    assign tick = &tickCount;

    assign bodyPass = (state == stDrawBody) || (state == stEraseBody);
    assign lastSquare = squareDone && (segIndex == '0);

    // counts down to the head and rearms at the tail for the next pass
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segIndex <= LastSegment;
        end
        else if (bodyPass && squareDone)
        begin
            segIndex <= (segIndex == '0) ? LastSegment : segIndex - 1'b1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= stIdle;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState = state;
        case (state)
            stIdle:
                if (go && tick)
                    nextState = stApple;
            stApple:
                if (squareDone)
                    nextState = stDrawBody;
            stDrawBody:
                if (lastSquare)
                    nextState = stWaitTick;
            // picture stays up for the rest of the frame
            stWaitTick:
                if (tick)
                    nextState = stEraseBody;
            stEraseBody:
                if (lastSquare)
                    nextState = stCheck;
            // collision is judged on the pre-move head
            stCheck:
                nextState = (borderHit || bodyHit) ? stOver : stMove;
            stMove:
                nextState = stApple;
            // only reset leaves here
            stOver:
                nextState = stOver;
            default:
                nextState = stIdle;
        endcase
    end

    // painter controls
    assign drawEnable = (state == stApple) || bodyPass;
    assign drawApple = (state == stApple);
    assign erase = (state == stEraseBody);
    assign segmentSelect = segIndex;

    // single cycle pulse so the chain shifts on the following edge
    assign moveEnable = (state == stMove);
    assign gameOver = (state == stOver);

endmodule

`default_nettype wire

// File: snakeGame.sv
// top level with control, steering, painter and the body segment chain
`timescale 1ns/10ps
`default_nettype none

module snakeGame
    import snakePkg::*;
#(
    parameter int SegmentCount = 4,
    parameter int CellSize = 10,
    parameter int TickBits = 20
)
(
    input wire Clock,
    input wire reset,
    input wire go,
    input wire [3:0] keys,
    input wire colour playerColour,
    output xCoord pixelX,
    output yCoord pixelY,
    output colour pixelColour,
    output logic plot,
    output logic gameOver
);

    localparam int XBits = $bits(xCoord);
    localparam int YBits = $bits(yCoord);

    logic drawEnable;
    logic drawApple;
    logic erase;
    logic moveEnable;
    logic [$clog2(SegmentCount)-1:0] segmentSelect;
    logic squareDone;
    logic borderHit;
    logic bodyHit;
    xCoord nextHeadX;
    yCoord nextHeadY;

    // segment i sits in slice i with the head in the low slice
    wire [SegmentCount*XBits-1:0] segmentX;
    wire [SegmentCount*YBits-1:0] segmentY;
    wire [SegmentCount-1:0] segmentHit;

    gameControl #(
        .SegmentCount(SegmentCount),
        .TickBits(TickBits)
    ) uControl (
        .Clock(Clock),
        .reset(reset),
        .go(go),
        .squareDone(squareDone),
        .borderHit(borderHit),
        .bodyHit(bodyHit),
        .drawEnable(drawEnable),
        .drawApple(drawApple),
        .erase(erase),
        .segmentSelect(segmentSelect),
        .moveEnable(moveEnable),
        .gameOver(gameOver)
    );

    headSteering #(
        .CellSize(CellSize)
    ) uSteering (
        .Clock(Clock),
        .reset(reset),
        .keys(keys),
        .headX(segmentX[XBits-1:0]),
        .headY(segmentY[YBits-1:0]),
        .nextHeadX(nextHeadX),
        .nextHeadY(nextHeadY),
        .borderHit(borderHit)
    );

    // head loads the steered cell and every other cell follows the one ahead
    for (genvar i = 0; i < SegmentCount; i++)
    begin : gSegment
        xCoord feedX;
        yCoord feedY;

        if (i == 0)
        begin : gFeedHead
            assign feedX = nextHeadX;
            assign feedY = nextHeadY;
        end
        else
        begin : gFeedBody
            assign feedX = segmentX[(i-1)*XBits +: XBits];
            assign feedY = segmentY[(i-1)*YBits +: YBits];
        end

        bodySegment #(
            .CellSize(CellSize),
            .Index(i)
        ) uSegment (
            .Clock(Clock),
            .reset(reset),
            .moveEnable(moveEnable),
            .inX(feedX),
            .inY(feedY),
            .headX(segmentX[XBits-1:0]),
            .headY(segmentY[YBits-1:0]),
            .posX(segmentX[i*XBits +: XBits]),
            .posY(segmentY[i*YBits +: YBits]),
            .hit(segmentHit[i])
        );
    end

    // any body cell under the head
    assign bodyHit = |segmentHit;

    squarePainter #(
        .SegmentCount(SegmentCount),
        .CellSize(CellSize)
    ) uPainter (
        .Clock(Clock),
        .reset(reset),
        .drawEnable(drawEnable),
        .drawApple(drawApple),
        .erase(erase),
        .segmentSelect(segmentSelect),
        .segmentX(segmentX),
        .segmentY(segmentY),
        .playerColour(playerColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .squareDone(squareDone)
    );

endmodule

`default_nettype wire

// File: tbSnakeGame.sv
// clock, reset, file driven rounds, segment chain model, pixel checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tbSnakeGame
    import snakePkg::*;
();

    localparam int SegmentCount = 4;
    localparam int CellSize = 10;
    localparam int TickBits = 4;
    localparam int TickPeriod = 2 ** TickBits;
    localparam int MaxRounds = 32;
    localparam int LineWords = 5;
    // pixels plus the idle cycle after each row
    localparam int SquareCycles = CellSize * (CellSize + 1);
    // apple, body draw, body erase, tick waits and a little slack
    localparam int RoundCycles = (1 + 2 * SegmentCount) * SquareCycles + 2 * TickPeriod + 16;
    localparam int IdleCycles = 4 * TickPeriod;
    localparam int QuietCycles = 3 * TickPeriod + 2 * SquareCycles;

    logic Clock;
    logic reset;
    logic go;
    logic [3:0] keys;
    colour playerColour;
    xCoord pixelX;
    yCoord pixelY;
    colour pixelColour;
    logic plot;
    logic gameOver;

    // five words per round line
    logic [7:0] tests [0:MaxRounds*LineWords-1];

    // expected pixel stream of the current round
    int expX[$];
    int expY[$];
    int expC[$];

    // model chain with the head at index 0
    int modelX [SegmentCount];
    int modelY [SegmentCount];
    direction modelDir;

    int roundCount;
    int gameCount;
    int watchdogCycles = 0;
    int pixelCount;
    int pixelErrors;
    int otherErrors;

    snakeGame #(
        .SegmentCount(SegmentCount),
        .CellSize(CellSize),
        .TickBits(TickBits)
    ) DUT (
        .Clock(Clock),
        .reset(reset),
        .go(go),
        .keys(keys),
        .playerColour(playerColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .gameOver(gameOver)
    );

    // 10 ns clock
    initial
    begin
        Clock = 1'b0;
        forever
        begin
            #5 Clock = ~Clock;
        end
    end

    // armed once the round count is known
    initial
    begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clock);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
            watchdogCycles);
        $display(">>> FAIL");
        $finish;
    end

    // start cells with the body hanging straight below the head
    task automatic resetModel();
        for (int i = 0; i < SegmentCount; i++)
        begin
            modelX[i] = int'(StartX);
            modelY[i] = int'(StartY) + CellSize * i;
        end
        modelDir = dirUp;
    endtask

    // reset pulse, idle check with go low, then go
    task automatic startGame();
        bit idleOk;
        idleOk = 1'b1;
        @(posedge Clock);
        #1;
        reset = 1'b1;
        go = 1'b0;
        keys = 4'hF;
        repeat (2) @(posedge Clock);
        #1;
        reset = 1'b0;
        resetModel();
        repeat (IdleCycles)
        begin
            @(negedge Clock);
            if (idleOk && plot)
            begin
                otherErrors++;
                $display("mismatch at %0t: plot expected 0 got %0b before go", $time, plot);
                idleOk = 1'b0;
            end
            if (idleOk && gameOver)
            begin
                otherErrors++;
                $display("mismatch at %0t: gameOver expected 0 got %0b before go",
                    $time, gameOver);
                idleOk = 1'b0;
            end
        end
        @(posedge Clock);
        #1;
        go = 1'b1;
    endtask

    // row by row and left to right
    task automatic addSquare(input int originX, input int originY, input int squareColour);
        for (int row = 0; row < CellSize; row++)
        begin
            for (int col = 0; col < CellSize; col++)
            begin
                expX.push_back(originX + col);
                expY.push_back(originY + row);
                expC.push_back(squareColour);
            end
        end
    endtask

    // apple, body tail to head, then the same body in black
    task automatic buildExpected(input colour roundColour);
        expX.delete();
        expY.delete();
        expC.delete();
        addSquare(int'(AppleX), int'(AppleY), int'(AppleColour));
        for (int i = SegmentCount - 1; i >= 0; i--)
        begin
            addSquare(modelX[i], modelY[i], int'(roundColour));
        end
        for (int i = SegmentCount - 1; i >= 0; i--)
        begin
            addSquare(modelX[i], modelY[i], int'(EraseColour));
        end
    endtask

    task automatic checkPixel(input int idx);
        pixelCount++;
        if (int'(pixelX) != expX[idx])
        begin
            pixelErrors++;
            $display("mismatch at %0t: pixelX expected %0d got %0d (pixel %0d)",
                $time, expX[idx], pixelX, idx);
        end
        if (int'(pixelY) != expY[idx])
        begin
            pixelErrors++;
            $display("mismatch at %0t: pixelY expected %0d got %0d (pixel %0d)",
                $time, expY[idx], pixelY, idx);
        end
        if (int'(pixelColour) != expC[idx])
        begin
            pixelErrors++;
            $display("mismatch at %0t: pixelColour expected %0d got %0d (pixel %0d)",
                $time, expC[idx], pixelColour, idx);
        end
    endtask

    // first apple pixel of the round sampled mid cycle
    task automatic waitFirstPlot(output bit found);
        bit stop;
        found = 1'b0;
        stop = 1'b0;
        while (!stop)
        begin
            @(negedge Clock);
            if (gameOver)
            begin
                otherErrors++;
                $display("mismatch at %0t: gameOver expected 0 got %0b before the round",
                    $time, gameOver);
                stop = 1'b1;
            end
            else if (plot)
            begin
                found = 1'b1;
                stop = 1'b1;
            end
        end
    endtask

    // rest of the round with new keys and colour right after the first pixel
    task automatic collectRound(input logic [3:0] roundKeys, input colour roundColour,
        output bit complete);
        int idx;
        int total;
        total = expX.size();
        complete = 1'b1;
        checkPixel(0);
        @(posedge Clock);
        #1;
        keys = roundKeys;
        playerColour = roundColour;
        idx = 1;
        while (complete && idx < total)
        begin
            @(negedge Clock);
            if (gameOver)
            begin
                otherErrors++;
                $display("mismatch at %0t: gameOver expected 0 got %0b during a round",
                    $time, gameOver);
                complete = 1'b0;
            end
            else if (plot)
            begin
                checkPixel(idx);
                idx++;
            end
        end
    endtask

    // key priority right, down, up, left
    // collision judged before the move
    task automatic stepModel(input logic [3:0] roundKeys, output bit over);
        int headX;
        int headY;
        bit hitBody;
        if (!roundKeys[0])
        begin
            modelDir = dirRight;
        end
        else if (!roundKeys[1])
        begin
            modelDir = dirDown;
        end
        else if (!roundKeys[2])
        begin
            modelDir = dirUp;
        end
        else if (!roundKeys[3])
        begin
            modelDir = dirLeft;
        end
        headX = modelX[0];
        headY = modelY[0];
        hitBody = 1'b0;
        for (int i = 1; i < SegmentCount; i++)
        begin
            if (modelX[i] == headX && modelY[i] == headY)
            begin
                hitBody = 1'b1;
            end
        end
        over = hitBody || headX == 0 || headX == ScreenWidth - CellSize
            || headY == 0 || headY == ScreenHeight - CellSize;
        if (!over)
        begin
            // body follows from the tail
            for (int i = SegmentCount - 1; i > 0; i--)
            begin
                modelX[i] = modelX[i-1];
                modelY[i] = modelY[i-1];
            end
            case (modelDir)
                dirRight:
                    modelX[0] = headX + CellSize;
                dirLeft:
                    modelX[0] = headX - CellSize;
                dirDown:
                    modelY[0] = headY + CellSize;
                default:
                    modelY[0] = headY - CellSize;
            endcase
        end
    endtask

    // flag must rise within a few cycles and nothing plots afterwards
    task automatic checkOver();
        bit risen;
        bit quietOk;
        risen = 1'b0;
        quietOk = 1'b1;
        for (int cycle = 0; cycle < 8 && !risen; cycle++)
        begin
            @(negedge Clock);
            if (plot)
            begin
                otherErrors++;
                $display("mismatch at %0t: plot expected 0 got %0b after the last round",
                    $time, plot);
            end
            risen = gameOver;
        end
        if (!risen)
        begin
            otherErrors++;
            $display("gameOver never rose after the round that should collide");
        end
        repeat (QuietCycles)
        begin
            @(negedge Clock);
            if (quietOk && plot)
            begin
                otherErrors++;
                $display("mismatch at %0t: plot expected 0 got %0b after game over",
                    $time, plot);
                quietOk = 1'b0;
            end
            if (quietOk && !gameOver)
            begin
                otherErrors++;
                $display("mismatch at %0t: gameOver expected 1 got %0b after game over",
                    $time, gameOver);
                quietOk = 1'b0;
            end
        end
    endtask

    initial
    begin
        int base;
        int fileX;
        int fileY;
        bit fileOver;
        bit modelOver;
        bit found;
        bit complete;
        bit needStart;
        logic [3:0] roundKeys;
        colour roundColour;

        reset = 1'b0;
        go = 1'b0;
        keys = 4'hF;
        playerColour = '0;
        pixelCount = 0;
        pixelErrors = 0;
        otherErrors = 0;
        // one seed for all random colours
        void'($urandom(86));

        // words past the file end stay above every key code
        for (int a = 0; a < MaxRounds * LineWords; a++)
        begin
            tests[a] = 8'(16 + a);
        end
        $readmemh("snakeTests.txt", tests);

        roundCount = 0;
        gameCount = 1;
        while (roundCount < MaxRounds && tests[roundCount*LineWords] < 8'h10)
        begin
            if (tests[roundCount*LineWords+4] != 8'h00)
            begin
                gameCount++;
            end
            roundCount++;
        end
        if (roundCount == 0)
        begin
            otherErrors++;
            $display("no rounds could be read from snakeTests.txt");
        end
        watchdogCycles = (roundCount + 1) * RoundCycles
            + gameCount * (IdleCycles + QuietCycles + 16);

        needStart = 1'b1;
        for (int line = 0; line < roundCount; line++)
        begin
            base = line * LineWords;
            if (needStart)
            begin
                startGame();
                needStart = 1'b0;
            end
            roundKeys = tests[base][3:0];
            // colour code 8 asks for a random colour
            if (tests[base+1] == 8'd8)
            begin
                roundColour = colour'($urandom % 8);
            end
            else
            begin
                roundColour = colour'(tests[base+1]);
            end
            fileX = int'(tests[base+2]);
            fileY = int'(tests[base+3]);
            fileOver = (tests[base+4] != 8'h00);

            buildExpected(roundColour);
            waitFirstPlot(found);
            if (!found)
            begin
                break;
            end
            collectRound(roundKeys, roundColour, complete);
            if (!complete)
            begin
                break;
            end

            stepModel(roundKeys, modelOver);
            if (modelX[0] != fileX || modelY[0] != fileY)
            begin
                otherErrors++;
                $display("test line %0d expects the head at (%0d,%0d) but the rules give (%0d,%0d)",
                    line, fileX, fileY, modelX[0], modelY[0]);
            end
            if (modelOver != fileOver)
            begin
                otherErrors++;
                $display("test line %0d game-over flag %0b disagrees with the rules (%0b)",
                    line, fileOver, modelOver);
            end
            if (modelOver)
            begin
                checkOver();
                needStart = 1'b1;
            end
        end

        $display("checked %0d pixels over %0d rounds: %0d pixel mismatches, %0d other errors",
            pixelCount, roundCount, pixelErrors, otherErrors);
        if (pixelErrors + otherErrors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
snakePkg.sv
headSteering.sv
bodySegment.sv
squarePainter.sv
gameControl.sv
snakeGame.sv
tbSnakeGame.sv

// File: run.sh
#!/bin/sh
# compile the snake game testbench with Verilator, run it, judge the log

rm -f sim.log

verilator --binary --timing -j 0 -f build.f --top-module tbSnakeGame -o simSnake \
    && ./obj_dir/simSnake > sim.log 2>&1 \
    || echo "build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "^>>> PASS$" sim.log && echo "run.sh: simulation passed" && exit 0 \
    || echo "run.sh: simulation failed" && exit 1

// File: snakeTests.txt
// one round per line, hex: keys colour headX headY over
// keys active low (bit0 right, bit1 down, bit2 up, bit3 left), colour 8 means random
// headX headY is the head after the round's move, over is the game-over flag of that round
// a round with over set ends the game, the next line starts a new game after reset

// game 1, steer around then reverse into the body
F 2 50 32 0
E 8 5A 32 0
D 1 5A 3C 0
7 8 50 3C 0
E 6 5A 3C 0
F 3 5A 3C 1

// game 2, several keys at once, then up into the top border
0 5 5A 3C 0
3 8 5A 32 0
F 7 5A 28 0
F 2 5A 1E 0
F 8 5A 14 0
F 4 5A 0A 0
F 1 5A 00 0
F 6 5A 00 1
